// ==== dv/exe_stage_tests.svh ====
`ifndef EXE_STAGE_TESTS_SVH
`define EXE_STAGE_TESTS_SVH

// reference model
function automatic logic [xlen-1:0] alu_model(input alu_op_e op, input logic [xlen-1:0] a,
	input logic [xlen-1:0] b);
	logic [4:0]      sh;
	logic [xlen-1:0] r;
	sh = b[4:0];
	r  = '0;
	case (op)
		alu_add:   r = a + b;
		alu_sub:   r = a - b;
		alu_and:   r = a & b;
		alu_or:    r = a | b;
		alu_xor:   r = a ^ b;
		alu_sll:   r = a << sh;
		alu_srl:   r = a >> sh;
		// logical shift and refill of the vacated top bits with the sign
		alu_sra:   r = a[xlen-1] ? ((a >> sh) | ~({xlen{1'b1}} >> sh)) : (a >> sh);
		alu_slt:   r[0] = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b);
		alu_sltu:  r[0] = a < b;
		alu_passb: r = b;
		default:   r = '0;
	endcase
	return r;
endfunction

function automatic logic [3:0] be_model(input store_size_e size, input logic [1:0] off);
	logic [3:0] be;
	be = '0;
	case (size)
		st_byte: be[off] = 1'b1;
		st_half: be = (off == 2'd0) ? 4'b0011 : (off == 2'd1) ? 4'b0110 :
			(off == 2'd2) ? 4'b1100 : 4'b1000;
		st_word: be = 4'b1111;
		default: be = '0;
	endcase
	return be;
endfunction

function automatic logic misalign_model(input store_size_e size, input logic [1:0] off);
	return (size == st_half && off[0]) || (size == st_word && off != 2'd0);
endfunction

task automatic reset_values();
	@(negedge clk);
	check_result('0, '0, 1'b0, 1'b0);
	flag_compare("mem_misaligned", mem_misaligned, 1'b0);
	word_compare("mem_addr", mem_addr, '0);
	word_compare("mem_store_data", mem_store_data, '0);
	be_compare("mem_byte_en", mem_byte_en, '0);
	dm_compare("mem_dm_select", mem_dm_select, '0);
endtask

task automatic alu_opcodes();
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] r;
	for (int i = 0; i <= 10; i++) begin
		repeat (3) begin
			a = next_random();
			b = next_random();
			r = next_random();
			send(alu_op_e'(i), a, b, '0, '0, sel_alu, r[4:0], 1'b1, 1'b0, st_byte, '0);
			wait_result();
			check_result(alu_model(alu_op_e'(i), a, b), r[4:0], 1'b1, 1'b0);
		end
	end
endtask

task automatic wb_select();
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] ext;
	a   = next_random();
	b   = next_random();
	ext = '0;
	ext[pc_w-1:0] = a[pc_w-1:0];
	send(alu_add, b, a, '0, a[pc_w-1:0], sel_pc4, 5'd1, 1'b1, 1'b0, st_byte, '0);
	wait_result();
	check_result(ext, 5'd1, 1'b1, 1'b0);
	send(alu_add, a, a, b, '0, sel_imm, 5'd2, 1'b1, 1'b0, st_byte, '0);
	wait_result();
	check_result(b, 5'd2, 1'b1, 1'b0);
	// load marks the read and carries the ALU sum
	send(alu_add, a, b, '0, '0, sel_mem, 5'd3, 1'b1, 1'b0, st_word, '0);
	wait_result();
	check_result(a + b, 5'd3, 1'b1, 1'b1);
endtask

task automatic store_lanes();
	logic [xlen-1:0] base;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] sd;
	logic [1:0]      off;
	logic            mis;
	for (int s = 0; s < 3; s++) begin
		for (int o = 0; o < 4; o++) begin
			off  = o[1:0];
			base = next_random() & ~32'h3;
			imm  = (next_random() & ~32'h3) | {30'b0, off};
			sd   = next_random();
			mis  = misalign_model(store_size_e'(s), off);
			send(alu_add, base, '0, imm, '0, sel_alu, '0, 1'b0, 1'b1, store_size_e'(s), sd);
			wait_result();
			word_compare("mem_addr", mem_addr, base + imm);
			word_compare("mem_store_data", mem_store_data, sd << (8 * off));
			be_compare("mem_byte_en", mem_byte_en, be_model(store_size_e'(s), off));
			flag_compare("mem_misaligned", mem_misaligned, mis);
			flag_compare("mem_we", mem_we, !mis);
			flag_compare("mem_reg_we", mem_reg_we, 1'b0);
			dm_compare("mem_dm_select", mem_dm_select, s[dm_w-1:0]);
		end
	end
endtask

task automatic stall_and_flush();
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] c;
	a = next_random();
	b = next_random();
	c = next_random();
	send(alu_xor, a, b, '0, '0, sel_alu, 5'd3, 1'b1, 1'b0, st_byte, '0);
	send(alu_sub, b, a, '0, '0, sel_alu, 5'd4, 1'b1, 1'b0, st_byte, '0);
	// third instruction waits at the inputs while stalled
	send(alu_add, '0, '0, c, '0, sel_imm, 5'd5, 1'b1, 1'b0, st_byte, '0);
	stall <= 1'b1;
	@(negedge clk);
	check_result(a ^ b, 5'd3, 1'b1, 1'b0);
	repeat (3) begin
		@(posedge clk);
		@(negedge clk);
		check_result(a ^ b, 5'd3, 1'b1, 1'b0);
	end
	@(posedge clk);
	stall <= 1'b0;
	@(negedge clk);
	check_result(a ^ b, 5'd3, 1'b1, 1'b0);
	drive_idle();
	@(negedge clk);
	check_result(b - a, 5'd4, 1'b1, 1'b0);
	@(posedge clk);
	@(negedge clk);
	check_result(c, 5'd5, 1'b1, 1'b0);
	// flushed store becomes a bubble
	send(alu_add, a & ~32'h3, '0, '0, '0, sel_alu, 5'd6, 1'b1, 1'b1, st_word, b);
	flush <= 1'b1;
	drive_idle();
	flush <= 1'b0;
	@(posedge clk);
	@(negedge clk);
	check_result('0, '0, 1'b0, 1'b0);
endtask

`endif

// ==== dv/exe_stage_tb.sv ====
`timescale 1ns/100ps

module exe_stage_tb;
	import cpu_pkg::*;

	localparam int num_tests   = 5;
	localparam int cycle_limit = 10 + 200 * num_tests;

	logic              clk;
	logic              rst;
	logic              stall;
	logic              flush;
	logic [pc_w-1:0]   id_pc4;
	logic [xlen-1:0]   id_opa;
	logic [xlen-1:0]   id_opb;
	logic [xlen-1:0]   id_store_data;
	logic [xlen-1:0]   id_imm;
	logic [reg_w-1:0]  id_rd;
	alu_op_e           id_alu_op;
	logic              id_is_store;
	logic              id_reg_we;
	logic [dm_w-1:0]   id_dm_select;
	sel_data_e         id_sel_data;
	store_size_e       id_store_size;
	logic [xlen-1:0]   mem_wb_data;
	logic [xlen-1:0]   mem_addr;
	logic [xlen-1:0]   mem_store_data;
	logic [3:0]        mem_byte_en;
	logic              mem_we;
	logic              mem_re;
	logic              mem_reg_we;
	logic              mem_misaligned;
	logic [dm_w-1:0]   mem_dm_select;
	logic [reg_w-1:0]  mem_rd;

	int          mismatches = 0;
	int          failures = 0;
	int          cycles = 0;
	logic [31:0] rng_state = 32'h5a53;

	exe_stage dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: tests did not finish within %0d cycles", cycle_limit);
			failures++;
			report_counts();
			$display("Done: errors found");
			$finish;
		end
	end

	// xorshift32
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic word_compare(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic be_compare(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic flag_compare(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic rd_compare(input string name, input logic [reg_w-1:0] got,
		input logic [reg_w-1:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic dm_compare(input string name, input logic [dm_w-1:0] got,
		input logic [dm_w-1:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
	endtask

	// idle inputs write neither registers nor memory
	task automatic clear_inputs();
		id_pc4        <= '0;
		id_opa        <= '0;
		id_opb        <= '0;
		id_store_data <= '0;
		id_imm        <= '0;
		id_rd         <= '0;
		id_alu_op     <= alu_add;
		id_is_store   <= 1'b0;
		id_reg_we     <= 1'b0;
		id_dm_select  <= '0;
		id_sel_data   <= sel_alu;
		id_store_size <= st_byte;
	endtask

	task automatic send(input alu_op_e op, input logic [xlen-1:0] a, input logic [xlen-1:0] b,
		input logic [xlen-1:0] imm, input logic [pc_w-1:0] pc4, input sel_data_e sel,
		input logic [reg_w-1:0] rd, input logic we, input logic st, input store_size_e size,
		input logic [xlen-1:0] sd);
		@(posedge clk);
		id_alu_op     <= op;
		id_opa        <= a;
		id_opb        <= b;
		id_imm        <= imm;
		id_pc4        <= pc4;
		id_sel_data   <= sel;
		id_rd         <= rd;
		id_reg_we     <= we;
		id_is_store   <= st;
		id_store_size <= size;
		id_dm_select  <= {1'b0, size};
		id_store_data <= sd;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		clear_inputs();
	endtask

	// instruction sent last reaches the mem_ outputs two edges later
	task automatic wait_result();
		drive_idle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic check_result(input logic [xlen-1:0] wb, input logic [reg_w-1:0] rd,
		input logic reg_we, input logic re);
		word_compare("mem_wb_data", mem_wb_data, wb);
		rd_compare("mem_rd", mem_rd, rd);
		flag_compare("mem_reg_we", mem_reg_we, reg_we);
		flag_compare("mem_re", mem_re, re);
		flag_compare("mem_we", mem_we, 1'b0);
	endtask

	`include "exe_stage_tests.svh"

	initial begin
		rst   = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		clear_inputs();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		reset_values();
		alu_opcodes();
		wb_select();
		store_lanes();
		stall_and_flush();
		repeat (2) @(posedge clk);
		report_counts();
		if (mismatches == 0 && failures == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== exe_stage.f ====
source/cpu_pkg.sv
source/exe_bundle_if.sv
source/id_exe_reg.sv
source/exe_alu.sv
source/exe_store_align.sv
source/exe_mem_reg.sv
source/exe_stage.sv
+incdir+dv
dv/exe_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f exe_stage.f --top-module exe_stage_tb -o exe_stage_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/exe_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// datapath widths
	localparam int xlen  = 32;
	localparam int pc_w  = 12;
	localparam int reg_w = 5;
	// load/store size code handed to the memory stage
	localparam int dm_w  = 3;

	// ALU opcode, codes 11..15 are illegal
	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_and   = 4'd2,
		alu_or    = 4'd3,
		alu_xor   = 4'd4,
		alu_sll   = 4'd5,
		alu_srl   = 4'd6,
		alu_sra   = 4'd7,
		alu_slt   = 4'd8,
		alu_sltu  = 4'd9,
		alu_passb = 4'd10
	} alu_op_e;

	// writeback source
	// sel_mem marks a load, its data arrives in the memory stage
	typedef enum logic [1:0] {
		sel_alu = 2'd0,
		sel_pc4 = 2'd1,
		sel_imm = 2'd2,
		sel_mem = 2'd3
	} sel_data_e;

	// store access size
	typedef enum logic [1:0] {
		st_byte = 2'd0,
		st_half = 2'd1,
		st_word = 2'd2
	} store_size_e;

endpackage

// ==== source/exe_alu.sv ====
`timescale 1ns/100ps

module exe_alu (
	exe_bundle_if.sink                exe,
	output logic [cpu_pkg::xlen-1:0]  alu_result
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// only the low five bits of opb shift
	assign shamt       = exe.opb[4:0];
	assign lt_signed   = $signed(exe.opa) < $signed(exe.opb);
	assign lt_unsigned = exe.opa < exe.opb;

	always_comb begin
		case (exe.alu_op)
			alu_add: begin
				alu_result = exe.opa + exe.opb;
			end
			alu_sub: begin
				alu_result = exe.opa - exe.opb;
			end
			alu_and: begin
				alu_result = exe.opa & exe.opb;
			end
			alu_or: begin
				alu_result = exe.opa | exe.opb;
			end
			alu_xor: begin
				alu_result = exe.opa ^ exe.opb;
			end
			alu_sll: begin
				alu_result = exe.opa << shamt;
			end
			alu_srl: begin
				alu_result = exe.opa >> shamt;
			end
			alu_sra: begin
				alu_result = $unsigned($signed(exe.opa) >>> shamt);
			end
			alu_slt: begin
				alu_result = {{(xlen-1){1'b0}}, lt_signed};
			end
			alu_sltu: begin
				alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
			end
			alu_passb: begin
				alu_result = exe.opb;
			end
			// illegal codes
			default: begin
				alu_result = '0;
			end
		endcase
	end

	// decode must never send an illegal opcode that writes back
	legal_op_on_write: assert property (
		@(posedge exe.clk) exe.reg_we |-> (exe.alu_op inside {[alu_add:alu_passb]})
	) else $error("illegal ALU opcode %0h with reg_we set", exe.alu_op);

endmodule

// ==== source/exe_bundle_if.sv ====
`timescale 1ns/100ps

interface exe_bundle_if (
	input logic clk
);
	import cpu_pkg::*;

	// ID/EXE register contents
	logic [pc_w-1:0]  pc4;
	logic [xlen-1:0]  opa;
	logic [xlen-1:0]  opb;
	logic [xlen-1:0]  store_data;
	logic [xlen-1:0]  imm;
	logic [reg_w-1:0] rd;
	alu_op_e          alu_op;
	logic             is_store;
	logic             reg_we;
	logic [dm_w-1:0]  dm_select;
	sel_data_e        sel_data;
	store_size_e      store_size;

	// written by the pipeline register
	modport src (
		output pc4, opa, opb, store_data, imm, rd, alu_op,
		output is_store, reg_we, dm_select, sel_data, store_size
	);

	// read by the execute blocks, clk is for their checks
	modport sink (
		input clk,
		input pc4, opa, opb, store_data, imm, rd, alu_op,
		input is_store, reg_we, dm_select, sel_data, store_size
	);

endinterface

// ==== source/exe_mem_reg.sv ====
`timescale 1ns/100ps

module exe_mem_reg (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stall,
	exe_bundle_if.sink                exe,
	input  logic [cpu_pkg::xlen-1:0]  alu_result,
	input  logic [cpu_pkg::xlen-1:0]  addr,
	input  logic [cpu_pkg::xlen-1:0]  lane_data,
	input  logic [3:0]                byte_en,
	input  logic                      misaligned,
	output logic [cpu_pkg::xlen-1:0]  wb_data,
	output logic [cpu_pkg::xlen-1:0]  mem_addr,
	output logic [cpu_pkg::xlen-1:0]  mem_store_data,
	output logic [3:0]                mem_byte_en,
	output logic                      mem_we,
	output logic                      mem_re,
	output logic                      mem_reg_we,
	output logic                      mem_misaligned,
	output logic [cpu_pkg::dm_w-1:0]  mem_dm_select,
	output logic [cpu_pkg::reg_w-1:0] mem_rd
);
	import cpu_pkg::*;

	logic [xlen-1:0] wb_next;
	logic            we_next;
	logic            re_next;

	// writeback source, loads carry the address-side ALU result for now
	always_comb begin
		case (exe.sel_data)
			sel_pc4: begin
				wb_next = {{(xlen-pc_w){1'b0}}, exe.pc4};
			end
			sel_imm: begin
				wb_next = exe.imm;
			end
			default: begin
				wb_next = alu_result;
			end
		endcase
	end

	// misaligned stores never reach memory
	assign we_next = exe.is_store & ~misaligned;
	assign re_next = (exe.sel_data == sel_mem);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_data        <= '0;
			mem_addr       <= '0;
			mem_store_data <= '0;
			mem_byte_en    <= '0;
			mem_we         <= 1'b0;
			mem_re         <= 1'b0;
			mem_reg_we     <= 1'b0;
			mem_misaligned <= 1'b0;
			mem_dm_select  <= '0;
			mem_rd         <= '0;
		end else if (!stall) begin
			wb_data        <= wb_next;
			mem_addr       <= addr;
			mem_store_data <= lane_data;
			mem_byte_en    <= byte_en;
			mem_we         <= we_next;
			mem_re         <= re_next;
			mem_reg_we     <= exe.reg_we;
			mem_misaligned <= misaligned;
			mem_dm_select  <= exe.dm_select;
			mem_rd         <= exe.rd;
		end
	end

endmodule

// ==== source/exe_stage.sv ====
`timescale 1ns/100ps

module exe_stage (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stall,
	input  logic                      flush,
	input  logic [cpu_pkg::pc_w-1:0]  id_pc4,
	input  logic [cpu_pkg::xlen-1:0]  id_opa,
	input  logic [cpu_pkg::xlen-1:0]  id_opb,
	input  logic [cpu_pkg::xlen-1:0]  id_store_data,
	input  logic [cpu_pkg::xlen-1:0]  id_imm,
	input  logic [cpu_pkg::reg_w-1:0] id_rd,
	input  cpu_pkg::alu_op_e          id_alu_op,
	input  logic                      id_is_store,
	input  logic                      id_reg_we,
	input  logic [cpu_pkg::dm_w-1:0]  id_dm_select,
	input  cpu_pkg::sel_data_e        id_sel_data,
	input  cpu_pkg::store_size_e      id_store_size,
	output logic [cpu_pkg::xlen-1:0]  mem_wb_data,
	output logic [cpu_pkg::xlen-1:0]  mem_addr,
	output logic [cpu_pkg::xlen-1:0]  mem_store_data,
	output logic [3:0]                mem_byte_en,
	output logic                      mem_we,
	output logic                      mem_re,
	output logic                      mem_reg_we,
	output logic                      mem_misaligned,
	output logic [cpu_pkg::dm_w-1:0]  mem_dm_select,
	output logic [cpu_pkg::reg_w-1:0] mem_rd
);
	import cpu_pkg::*;

	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] lane_data;
	logic [3:0]      byte_en;
	logic            misaligned;

	exe_bundle_if exe_if (.clk(clk));

	id_exe_reg u_id_exe (
		.clk(clk), .rst(rst), .stall(stall), .flush(flush),
		.pc4(id_pc4), .opa(id_opa), .opb(id_opb),
		.store_data(id_store_data), .imm(id_imm), .rd(id_rd),
		.alu_op(id_alu_op), .is_store(id_is_store), .reg_we(id_reg_we),
		.dm_select(id_dm_select), .sel_data(id_sel_data),
		.store_size(id_store_size), .exe(exe_if.src)
	);

	// ALU and store aligner work side by side
	exe_alu u_alu (.exe(exe_if.sink), .alu_result(alu_result));

	exe_store_align u_store (
		.exe(exe_if.sink), .addr(addr), .lane_data(lane_data),
		.byte_en(byte_en), .misaligned(misaligned)
	);

	exe_mem_reg u_exe_mem (
		.clk(clk), .rst(rst), .stall(stall), .exe(exe_if.sink),
		.alu_result(alu_result), .addr(addr), .lane_data(lane_data),
		.byte_en(byte_en), .misaligned(misaligned),
		.wb_data(mem_wb_data), .mem_addr(mem_addr),
		.mem_store_data(mem_store_data), .mem_byte_en(mem_byte_en),
		.mem_we(mem_we), .mem_re(mem_re), .mem_reg_we(mem_reg_we),
		.mem_misaligned(mem_misaligned), .mem_dm_select(mem_dm_select),
		.mem_rd(mem_rd)
	);

endmodule

// ==== source/exe_store_align.sv ====
`timescale 1ns/100ps

module exe_store_align (
	exe_bundle_if.sink                exe,
	output logic [cpu_pkg::xlen-1:0]  addr,
	output logic [cpu_pkg::xlen-1:0]  lane_data,
	output logic [3:0]                byte_en,
	output logic                      misaligned
);
	import cpu_pkg::*;

	logic [1:0] offset;
	logic       bad_align;

	// effective address, base plus offset
	assign addr   = exe.opa + exe.imm;
	assign offset = addr[1:0];

	// move store data up to its byte lane
	assign lane_data = exe.store_data << {offset, 3'b000};

	always_comb begin
		case (exe.store_size)
			st_byte: begin
				byte_en   = 4'b0001 << offset;
				bad_align = 1'b0;
			end
			st_half: begin
				byte_en   = 4'b0011 << offset;
				bad_align = offset[0];
			end
			st_word: begin
				byte_en   = 4'b1111;
				bad_align = |offset;
			end
			default: begin
				byte_en   = 4'b0000;
				bad_align = 1'b0;
			end
		endcase
	end

	// only stores can be misaligned here
	assign misaligned = exe.is_store & bad_align;

	// a store arriving from ID/EXE always touches some byte
	store_has_lanes: assert property (
		@(posedge exe.clk) exe.is_store |-> (byte_en != 4'b0000)
	) else $error("store with empty byte enables, size %0d", exe.store_size);

endmodule

// ==== source/id_exe_reg.sv ====
`timescale 1ns/100ps

module id_exe_reg (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stall,
	input  logic                      flush,
	input  logic [cpu_pkg::pc_w-1:0]  pc4,
	input  logic [cpu_pkg::xlen-1:0]  opa,
	input  logic [cpu_pkg::xlen-1:0]  opb,
	input  logic [cpu_pkg::xlen-1:0]  store_data,
	input  logic [cpu_pkg::xlen-1:0]  imm,
	input  logic [cpu_pkg::reg_w-1:0] rd,
	input  cpu_pkg::alu_op_e          alu_op,
	input  logic                      is_store,
	input  logic                      reg_we,
	input  logic [cpu_pkg::dm_w-1:0]  dm_select,
	input  cpu_pkg::sel_data_e        sel_data,
	input  cpu_pkg::store_size_e      store_size,
	exe_bundle_if.src                 exe
);
	import cpu_pkg::*;

	// flush beats stall and loads an all-zero bubble
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			exe.pc4        <= '0;
			exe.opa        <= '0;
			exe.opb        <= '0;
			exe.store_data <= '0;
			exe.imm        <= '0;
			exe.rd         <= '0;
			exe.alu_op     <= alu_add;
			exe.is_store   <= 1'b0;
			exe.reg_we     <= 1'b0;
			exe.dm_select  <= '0;
			exe.sel_data   <= sel_alu;
			exe.store_size <= st_byte;
		end else if (!stall) begin
			exe.pc4        <= pc4;
			exe.opa        <= opa;
			exe.opb        <= opb;
			exe.store_data <= store_data;
			exe.imm        <= imm;
			exe.rd         <= rd;
			exe.alu_op     <= alu_op;
			exe.is_store   <= is_store;
			exe.reg_we     <= reg_we;
			exe.dm_select  <= dm_select;
			exe.sel_data   <= sel_data;
			exe.store_size <= store_size;
		end
	end

endmodule
